// File: files.f
+incdir+rtl
rtl/lsu_pkg.sv
rtl/lsu_dmem.sv
rtl/lsu_periph_regs.sv
rtl/lsu_load_align.sv
rtl/lsu_top.sv
verification/tb_clkgen.sv
verification/tb_lsu.sv

// File: rtl/lsu_dmem.sv
// ==========================================================
// No reset on the arrays, so contents are undefined until written
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_dmem (
        input  logic                             clk_i,
        input  logic                             we_i,
        input  logic [lsu_pkg::DMEM_IDX_W-1:0]   word_idx_i,
        input  logic [`LSU_DATA_W-1:0]           wr_data_i,
        input  logic [`LSU_MASK_W-1:0]           bmask_i,
        output logic [`LSU_DATA_W-1:0]           rd_word_o
);

        // Illegal masks block the whole store
        logic wr_ok;

        assign wr_ok = we_i && `LSU_MASK_OK(bmask_i);

        // ==========================================================
        // One byte-wide array per lane
        // ==========================================================
        for (genvar k = 0; k < `LSU_MASK_W; k++) begin : g_lane
                logic [`LSU_BYTE_W-1:0] lane_mem [`LSU_DMEM_WORDS];

                // Lane k takes data byte k
                always_ff @(posedge clk_i) begin : lane_write
                        if (wr_ok && bmask_i[k]) begin
                                lane_mem[word_idx_i] <=
                                        wr_data_i[k*`LSU_BYTE_W +: `LSU_BYTE_W];
                        end
                end

                // Asynchronous word read
                assign rd_word_o[k*`LSU_BYTE_W +: `LSU_BYTE_W] = lane_mem[word_idx_i];
        end

endmodule

`default_nettype wire

// File: rtl/lsu_load_align.sv
// ==========================================================
// Lane comes from the byte mask and not from the address
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_load_align (
        input  logic [1:0]                 region_i,
        input  logic [`LSU_DATA_W-1:0]     dmem_word_i,
        input  logic [`LSU_DATA_W-1:0]     peri_word_i,
        input  logic [`LSU_MASK_W-1:0]     bmask_i,
        output logic [`LSU_DATA_W-1:0]     rd_data_o
);

        logic [`LSU_DATA_W-1:0] src_word;
        logic                   sign_ext;

        function automatic logic [`LSU_DATA_W-1:0] ext_byte(
                input logic [`LSU_BYTE_W-1:0] b,
                input logic                   sgn
        );
                ext_byte = {{(`LSU_DATA_W-`LSU_BYTE_W){sgn & b[`LSU_BYTE_W-1]}}, b};
        endfunction

        function automatic logic [`LSU_DATA_W-1:0] ext_half(
                input logic [2*`LSU_BYTE_W-1:0] h,
                input logic                     sgn
        );
                ext_half = {{(`LSU_DATA_W-2*`LSU_BYTE_W){sgn & h[2*`LSU_BYTE_W-1]}}, h};
        endfunction

        // ==========================================================
        // Region word select
        // ==========================================================
        always_comb begin : word_select
                src_word = '0;
                sign_ext = 1'b0;
                case (region_i)
                        `LSU_RGN_DMEM: begin
                                src_word = dmem_word_i;
                                sign_ext = 1'b1;
                        end
                        `LSU_RGN_PERI: begin
                                src_word = peri_word_i;
                        end
                        // Reserved space reads as zero
                        default: ;
                endcase
        end

        // Lane extraction
        always_comb begin : lane_extract
                case (bmask_i)
                        `LSU_MASK_B0:   rd_data_o = ext_byte(src_word[7:0], sign_ext);
                        `LSU_MASK_B1:   rd_data_o = ext_byte(src_word[15:8], sign_ext);
                        `LSU_MASK_B2:   rd_data_o = ext_byte(src_word[23:16], sign_ext);
                        `LSU_MASK_B3:   rd_data_o = ext_byte(src_word[31:24], sign_ext);
                        `LSU_MASK_H0:   rd_data_o = ext_half(src_word[15:0], sign_ext);
                        `LSU_MASK_H1:   rd_data_o = ext_half(src_word[31:16], sign_ext);
                        `LSU_MASK_WORD: rd_data_o = src_word;
                        default:        rd_data_o = '0;
                endcase
        end

endmodule

`default_nettype wire

// File: rtl/lsu_macros.svh
// ==========================================================
// 12-bit byte addresses with data memory based at address 0
// Peripheral offsets are byte offsets from LSU_PERI_BASE
// ==========================================================
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// Widths
`define LSU_ADDR_W      12
`define LSU_DATA_W      32
`define LSU_MASK_W      4
`define LSU_BYTE_W      8

// Address map
`define LSU_DMEM_WORDS  512
`define LSU_PERI_BASE   12'h800
`define LSU_RESV_BASE   12'hA00

// Peripheral register offsets
`define LSU_LCD_OFS     'h00
`define LSU_HEX_OFS     'h20
`define LSU_LEDR_OFS    'h40
`define LSU_LEDG_OFS    'h44
`define LSU_LCD_NUM     8
`define LSU_HEX_NUM     8

// Region select between decoder and load aligner
`define LSU_RGN_DMEM    2'd0
`define LSU_RGN_PERI    2'd1
`define LSU_RGN_RESV    2'd2

// ==========================================================
// Legal byte masks
// ==========================================================
`define LSU_MASK_B0     4'b0001
`define LSU_MASK_B1     4'b0010
`define LSU_MASK_B2     4'b0100
`define LSU_MASK_B3     4'b1000
`define LSU_MASK_H0     4'b0011
`define LSU_MASK_H1     4'b1100
`define LSU_MASK_WORD   4'b1111

`define LSU_MASK_OK(m) ((m) == `LSU_MASK_B0 || (m) == `LSU_MASK_B1 || \
                        (m) == `LSU_MASK_B2 || (m) == `LSU_MASK_B3 || \
                        (m) == `LSU_MASK_H0 || (m) == `LSU_MASK_H1 || \
                        (m) == `LSU_MASK_WORD)

`endif

// File: rtl/lsu_periph_regs.sv
// ==========================================================
// HEX and LED keep byte 0 only, unmapped offsets read zero
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_periph_regs (
        input  logic                                    clk_i,
        input  logic                                    rst_ni,
        input  logic                                    we_i,
        input  logic [lsu_pkg::PERI_IDX_W-1:0]          reg_idx_i,
        input  logic [`LSU_DATA_W-1:0]                  wr_data_i,
        input  logic [`LSU_MASK_W-1:0]                  bmask_i,
        output logic [`LSU_DATA_W-1:0]                  rd_word_o,
        output logic [`LSU_LCD_NUM*`LSU_DATA_W-1:0]     lcd_o,
        output logic [`LSU_HEX_NUM*`LSU_BYTE_W-1:0]     hex_o,
        output logic [`LSU_BYTE_W-1:0]                  ledr_o,
        output logic [`LSU_BYTE_W-1:0]                  ledg_o
);

        import lsu_pkg::*;

        // Word indices within the peripheral window
        localparam logic [PERI_IDX_W-1:0] LCD_IDX  = PERI_IDX_W'(`LSU_LCD_OFS >> BOFS_W);
        localparam logic [PERI_IDX_W-1:0] HEX_IDX  = PERI_IDX_W'(`LSU_HEX_OFS >> BOFS_W);
        localparam logic [PERI_IDX_W-1:0] LEDR_IDX = PERI_IDX_W'(`LSU_LEDR_OFS >> BOFS_W);
        localparam logic [PERI_IDX_W-1:0] LEDG_IDX = PERI_IDX_W'(`LSU_LEDG_OFS >> BOFS_W);
        localparam int unsigned LCD_SEL_W = $clog2(`LSU_LCD_NUM);
        localparam int unsigned HEX_SEL_W = $clog2(`LSU_HEX_NUM);

        logic [`LSU_LCD_NUM-1:0][`LSU_DATA_W-1:0] lcd_q;
        logic [`LSU_HEX_NUM-1:0][`LSU_BYTE_W-1:0] hex_q;
        logic [`LSU_BYTE_W-1:0]                   ledr_q;
        logic [`LSU_BYTE_W-1:0]                   ledg_q;

        logic                   lcd_hit, hex_hit, ledr_hit, ledg_hit;
        logic [PERI_IDX_W-1:0]  lcd_off, hex_off;
        logic [LCD_SEL_W-1:0]   lcd_sel;
        logic [HEX_SEL_W-1:0]   hex_sel;
        logic                   wr_ok;

        // ==========================================================
        // Offset decode
        // ==========================================================
        assign lcd_off  = reg_idx_i - LCD_IDX;
        assign hex_off  = reg_idx_i - HEX_IDX;
        assign lcd_sel  = lcd_off[LCD_SEL_W-1:0];
        assign hex_sel  = hex_off[HEX_SEL_W-1:0];
        assign lcd_hit  = (reg_idx_i >= LCD_IDX) &&
                          (reg_idx_i < LCD_IDX + PERI_IDX_W'(`LSU_LCD_NUM));
        assign hex_hit  = (reg_idx_i >= HEX_IDX) &&
                          (reg_idx_i < HEX_IDX + PERI_IDX_W'(`LSU_HEX_NUM));
        assign ledr_hit = (reg_idx_i == LEDR_IDX);
        assign ledg_hit = (reg_idx_i == LEDG_IDX);
        assign wr_ok    = we_i && `LSU_MASK_OK(bmask_i);

        // ==========================================================
        // Register writes
        // ==========================================================
        always_ff @(posedge clk_i or negedge rst_ni) begin : reg_write
                if (!rst_ni) begin
                        lcd_q  <= '0;
                        hex_q  <= '0;
                        ledr_q <= '0;
                        ledg_q <= '0;
                end else if (wr_ok) begin
                        // LCD words take every lane in the mask
                        if (lcd_hit) begin
                                for (int k = 0; k < `LSU_MASK_W; k++) begin
                                        if (bmask_i[k]) begin
                                                lcd_q[lcd_sel][k*`LSU_BYTE_W +: `LSU_BYTE_W] <=
                                                        wr_data_i[k*`LSU_BYTE_W +: `LSU_BYTE_W];
                                        end
                                end
                        end
                        if (hex_hit && bmask_i[0]) begin
                                hex_q[hex_sel] <= wr_data_i[`LSU_BYTE_W-1:0];
                        end
                        if (ledr_hit && bmask_i[0]) begin
                                ledr_q <= wr_data_i[`LSU_BYTE_W-1:0];
                        end
                        if (ledg_hit && bmask_i[0]) begin
                                ledg_q <= wr_data_i[`LSU_BYTE_W-1:0];
                        end
                end
        end

        // Word read, byte registers come back zero-extended
        always_comb begin : reg_read
                rd_word_o = '0;
                if (lcd_hit) begin
                        rd_word_o = lcd_q[lcd_sel];
                end else if (hex_hit) begin
                        rd_word_o = `LSU_DATA_W'(hex_q[hex_sel]);
                end else if (ledr_hit) begin
                        rd_word_o = `LSU_DATA_W'(ledr_q);
                end else if (ledg_hit) begin
                        rd_word_o = `LSU_DATA_W'(ledg_q);
                end
        end

        // Pins, LCD word 0 in the lowest bits
        assign lcd_o  = lcd_q;
        assign hex_o  = hex_q;
        assign ledr_o = ledr_q;
        assign ledg_o = ledg_q;

        // LEDs only move on a peripheral store
        a_led_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
                !we_i |=> ($stable(ledr_q) && $stable(ledg_q)));

endmodule

`default_nettype wire

// File: rtl/lsu_pkg.sv
// ==========================================================
// Field widths follow from the address map in the macros
// ==========================================================
`default_nettype none

`include "lsu_macros.svh"

package lsu_pkg;

        // Byte offset within a word
        localparam int unsigned BOFS_W      = $clog2(`LSU_MASK_W);
        localparam int unsigned DMEM_IDX_W  = $clog2(`LSU_DMEM_WORDS);
        localparam int unsigned DMEM_RGN_W  = `LSU_ADDR_W - DMEM_IDX_W - BOFS_W;

        // Peripheral window runs from LSU_PERI_BASE up to LSU_RESV_BASE
        localparam int unsigned PERI_SPAN_W = $clog2(`LSU_RESV_BASE - `LSU_PERI_BASE);
        localparam int unsigned PERI_RGN_W  = `LSU_ADDR_W - PERI_SPAN_W;
        localparam int unsigned PERI_IDX_W  = PERI_SPAN_W - BOFS_W;

        // One byte address, seen as data memory or peripheral address
        typedef union packed {
                struct packed {
                        logic [DMEM_RGN_W-1:0] region;
                        logic [DMEM_IDX_W-1:0] word_idx;
                        logic [BOFS_W-1:0]     byte_ofs;
                } dmem;
                struct packed {
                        logic [PERI_RGN_W-1:0] region;
                        logic [PERI_IDX_W-1:0] reg_idx;
                        logic [BOFS_W-1:0]     byte_ofs;
                } peri;
        } lsu_addr_u;

endpackage

`default_nettype wire

// File: rtl/lsu_top.sv
// ==========================================================
// One access per cycle, stores on the clock edge, loads combinational
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_top (
        input  logic                                 clk_i,
        input  logic                                 rst_ni,
        input  logic                                 mem_wren_i,
        input  logic [`LSU_ADDR_W-1:0]               lsu_addr_i,
        input  logic [`LSU_DATA_W-1:0]               wr_data_i,
        input  logic [`LSU_MASK_W-1:0]               bmask_i,
        output logic [`LSU_DATA_W-1:0]               rd_data_o,
        output logic [`LSU_LCD_NUM*`LSU_DATA_W-1:0]  lcd_o,
        output logic [`LSU_HEX_NUM*`LSU_BYTE_W-1:0]  hex_o,
        output logic [`LSU_BYTE_W-1:0]               ledr_o,
        output logic [`LSU_BYTE_W-1:0]               ledg_o
);

        import lsu_pkg::*;

        // Upper address bits of the peripheral window
        localparam logic [PERI_RGN_W-1:0] PERI_TAG =
                PERI_RGN_W'(`LSU_PERI_BASE >> PERI_SPAN_W);

        lsu_addr_u              addr;
        logic                   in_dmem, in_peri;
        logic                   dmem_we, peri_we;
        logic [1:0]             region;
        logic [`LSU_DATA_W-1:0] dmem_word, peri_word;

        // ==========================================================
        // Region decode and write steering
        // ==========================================================
        assign addr    = lsu_addr_i;
        assign in_dmem = (addr.dmem.region == '0);
        assign in_peri = (addr.peri.region == PERI_TAG);
        assign dmem_we = mem_wren_i && in_dmem;
        assign peri_we = mem_wren_i && in_peri;

        always_comb begin : region_sel
                if (in_dmem) begin
                        region = `LSU_RGN_DMEM;
                end else if (in_peri) begin
                        region = `LSU_RGN_PERI;
                end else begin
                        region = `LSU_RGN_RESV;
                end
        end

        lsu_dmem u_dmem (
                .clk_i      (clk_i),
                .we_i       (dmem_we),
                .word_idx_i (addr.dmem.word_idx),
                .wr_data_i  (wr_data_i),
                .bmask_i    (bmask_i),
                .rd_word_o  (dmem_word)
        );

        lsu_periph_regs u_periph (
                .clk_i      (clk_i),
                .rst_ni     (rst_ni),
                .we_i       (peri_we),
                .reg_idx_i  (addr.peri.reg_idx),
                .wr_data_i  (wr_data_i),
                .bmask_i    (bmask_i),
                .rd_word_o  (peri_word),
                .lcd_o      (lcd_o),
                .hex_o      (hex_o),
                .ledr_o     (ledr_o),
                .ledg_o     (ledg_o)
        );

        lsu_load_align u_align (
                .region_i    (region),
                .dmem_word_i (dmem_word),
                .peri_word_i (peri_word),
                .bmask_i     (bmask_i),
                .rd_data_o   (rd_data_o)
        );

        // Stores reaching either memory carry one of the seven legal masks
        a_store_mask: assert property (@(posedge clk_i) disable iff (!rst_ni)
                mem_wren_i |-> `LSU_MASK_OK(bmask_i));

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_lsu -f files.f

out=$(./obj_dir/Vtb_lsu)
echo "$out"
echo "$out" | grep -qx "Simulation completed successfully"

// File: verification/tb_clkgen.sv
// ==========================================================
// Free-running 40 ns clock, reset low for the first 8 edges
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen #(
        parameter int unsigned HALF_PERIOD_NS = 20,
        parameter int unsigned RST_CYCLES     = 8
) (
        output logic clk_o,
        output logic rst_no
);

        initial begin : clock_gen
                clk_o = 1'b0;
                forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
        end

        // Release just after an edge so no flop sees it change
        initial begin : reset_gen
                rst_no = 1'b0;
                repeat (RST_CYCLES) @(posedge clk_o);
                #2;
                rst_no = 1'b1;
        end

endmodule

`default_nettype wire

// File: verification/tb_lsu.sv
// ==========================================================
// Inputs change 2 ns after the rising edge, loads sampled at the falling edge
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

module tb_lsu;

        // Tests run in well under 600 cycles
        localparam int MAX_CYCLES = 2000;
        localparam logic [3:0] LOAD_MASKS [8] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                                  4'b0011, 4'b1100, 4'b1111, 4'b0101};

        logic         clk, rst_n, mem_wren;
        logic [11:0]  lsu_addr;
        logic [31:0]  wr_data, rd_data;
        logic [3:0]   bmask;
        logic [255:0] lcd;
        logic [63:0]  hex;
        logic [7:0]   ledr, ledg;

        // Reference model, data memory kept as bytes
        logic [7:0]   dmem_model [2048];
        logic [31:0]  lcd_model [8];
        logic [7:0]   hex_model [8];
        logic [7:0]   ledr_model, ledg_model;
        logic [11:0]  addr_list [32];

        int seed = 28;
        int cycles = 0;
        int checks = 0;
        int errors = 0;
        int errors_at_start = 0;
        int tests_passed = 0;
        int tests_failed = 0;

        tb_clkgen u_clkgen (.clk_o(clk), .rst_no(rst_n));

        lsu_top u_lsu_top (
                .clk_i      (clk),
                .rst_ni     (rst_n),
                .mem_wren_i (mem_wren),
                .lsu_addr_i (lsu_addr),
                .wr_data_i  (wr_data),
                .bmask_i    (bmask),
                .rd_data_o  (rd_data),
                .lcd_o      (lcd),
                .hex_o      (hex),
                .ledr_o     (ledr),
                .ledg_o     (ledg)
        );

        // ==========================================================
        // Reference model
        // ==========================================================
        function automatic logic mask_legal(input logic [3:0] m);
                case (m)
                        4'b0001, 4'b0010, 4'b0100, 4'b1000,
                        4'b0011, 4'b1100, 4'b1111: mask_legal = 1'b1;
                        default: mask_legal = 1'b0;
                endcase
        endfunction

        function automatic void model_store(input logic [11:0] a, input logic [31:0] d,
                                            input logic [3:0] m);
                int base;
                int idx;
                int k;
                base = int'(a[10:2]) * 4;
                idx = int'(a[8:2]);
                if (mask_legal(m) && a < 12'h800) begin
                        for (k = 0; k < 4; k++) begin
                                if (m[k]) begin
                                        dmem_model[base+k] = d[8*k +: 8];
                                end
                        end
                end else if (mask_legal(m) && a < 12'hA00) begin
                        if (idx < 8) begin
                                for (k = 0; k < 4; k++) begin
                                        if (m[k]) begin
                                                lcd_model[idx][8*k +: 8] = d[8*k +: 8];
                                        end
                                end
                        end else if (m[0] && idx < 16) begin
                                hex_model[idx-8] = d[7:0];
                        end else if (m[0] && idx == 16) begin
                                ledr_model = d[7:0];
                        end else if (m[0] && idx == 17) begin
                                ledg_model = d[7:0];
                        end
                end
        endfunction

        function automatic logic [31:0] expect_load(input logic [11:0] a, input logic [3:0] m);
                logic [31:0] w;
                logic        sgn;
                int          base;
                int          idx;
                w = 32'h0;
                sgn = 1'b0;
                base = int'(a[10:2]) * 4;
                idx = int'(a[8:2]);
                if (a < 12'h800) begin
                        w = {dmem_model[base+3], dmem_model[base+2],
                             dmem_model[base+1], dmem_model[base]};
                        sgn = 1'b1;
                end else if (a < 12'hA00) begin
                        if (idx < 8) begin
                                w = lcd_model[idx];
                        end else if (idx < 16) begin
                                w = {24'h0, hex_model[idx-8]};
                        end else if (idx == 16) begin
                                w = {24'h0, ledr_model};
                        end else if (idx == 17) begin
                                w = {24'h0, ledg_model};
                        end
                end
                case (m)
                        4'b0001: expect_load = {{24{sgn & w[7]}}, w[7:0]};
                        4'b0010: expect_load = {{24{sgn & w[15]}}, w[15:8]};
                        4'b0100: expect_load = {{24{sgn & w[23]}}, w[23:16]};
                        4'b1000: expect_load = {{24{sgn & w[31]}}, w[31:24]};
                        4'b0011: expect_load = {{16{sgn & w[15]}}, w[15:0]};
                        4'b1100: expect_load = {{16{sgn & w[31]}}, w[31:16]};
                        4'b1111: expect_load = w;
                        default: expect_load = 32'h0;
                endcase
        endfunction

        // ==========================================================
        // Bus actions and checks
        // ==========================================================
        task automatic drive(input logic we, input logic [11:0] a, input logic [31:0] d,
                             input logic [3:0] m);
                @(posedge clk);
                #2;
                mem_wren = we;
                lsu_addr = a;
                wr_data = d;
                bmask = m;
        endtask

        task automatic do_store(input logic [11:0] a, input logic [31:0] d, input logic [3:0] m);
                drive(1'b1, a, d, m);
                model_store(a, d, m);
        endtask

        task automatic check_eq(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
                checks++;
                assert (got === exp) else begin
                        errors++;
                        $display("ERR %0t: %s got %h, expected %h", $time, what, got, exp);
                end
        endtask

        task automatic check_load(input logic [11:0] a, input logic [3:0] m);
                drive(1'b0, a, 32'h0, m);
                @(negedge clk);
                check_eq($sformatf("load %h mask %b", a, m), rd_data, expect_load(a, m));
        endtask

        // Only valid right after check_load, once the last store has landed
        task automatic check_pins();
                int i;
                for (i = 0; i < 8; i++) begin
                        check_eq($sformatf("lcd_o word %0d", i), lcd[32*i +: 32], lcd_model[i]);
                        check_eq($sformatf("hex_o digit %0d", i), {24'h0, hex[8*i +: 8]},
                                 {24'h0, hex_model[i]});
                end
                check_eq("ledr_o", {24'h0, ledr}, {24'h0, ledr_model});
                check_eq("ledg_o", {24'h0, ledg}, {24'h0, ledg_model});
        endtask

        task automatic finish_test(input string name);
                if (errors == errors_at_start) begin
                        tests_passed++;
                        $display("Test %s: pass", name);
                end else begin
                        tests_failed++;
                        $display("Test %s: FAIL, %0d errors", name, errors - errors_at_start);
                end
                errors_at_start = errors;
        endtask

        // Reserved stores leave every pin untouched
        a_resv_store: assert property (@(posedge clk) disable iff (!rst_n)
                (mem_wren && lsu_addr >= 12'hA00) |=>
                        ($stable(lcd) && $stable(hex) && $stable(ledr) && $stable(ledg)))
                else begin
                        errors++;
                        $display("ERR %0t: reserved store changed a pin output", $time);
                end

        initial begin : watchdog
                while (cycles < MAX_CYCLES) begin
                        @(posedge clk);
                        cycles++;
                end
                $display("Timeout: no result after %0d clock cycles", MAX_CYCLES);
                $display("Simulation failed");
                $finish;
        end

        // ==========================================================
        // Stimulus
        // ==========================================================
        initial begin : stimulus
                logic [31:0] d;
                logic [11:0] a;
                int          i;
                int          k;
                mem_wren = 1'b0;
                lsu_addr = 12'h0;
                wr_data = 32'h0;
                bmask = 4'b1111;
                ledr_model = 8'h0;
                ledg_model = 8'h0;
                for (i = 0; i < 8; i++) begin
                        lcd_model[i] = 32'h0;
                        hex_model[i] = 8'h0;
                end
                @(posedge rst_n);

                check_load(12'h840, 4'b1111);
                check_pins();
                finish_test("reset state");

                // Distinct word indices, random low bits
                for (i = 0; i < 32; i++) begin
                        addr_list[i] = {1'b0, i[4:0], 4'($random(seed)), 2'b00};
                        do_store(addr_list[i], $random(seed), 4'b1111);
                end
                for (i = 0; i < 32; i++) begin
                        check_load(addr_list[i], 4'b1111);
                end
                finish_test("data memory words");

                // Byte then halfword over an old word, sign bit alternating
                for (i = 0; i < 8; i++) begin
                        a = addr_list[i];
                        k = i % 4;
                        do_store(a, $random(seed), 4'b1111);
                        d = $random(seed);
                        d[8*k+7] = ~i[0];
                        do_store(a, d, 4'b0001 << k);
                        check_load(a, 4'b1111);
                        d = $random(seed);
                        d[15] = ~i[0];
                        d[31] = i[0];
                        do_store(a, d, i[1] ? 4'b1100 : 4'b0011);
                        for (k = 0; k < 8; k++) begin
                                check_load(a, LOAD_MASKS[k]);
                        end
                end
                finish_test("data memory sub-word");

                for (i = 0; i < 8; i++) begin
                        a = 12'h800 + 12'(4 * i);
                        do_store(a, $random(seed) | 32'h8080_8080, 4'b1111);
                        do_store(a, $random(seed), 4'b0001 << (i % 4));
                        check_load(a, 4'b1111);
                        check_pins();
                        check_load(a, 4'b1100);
                        check_load(a, 4'b0001 << ((i + 1) % 4));
                end
                finish_test("lcd registers");

                // HEX digits then both LED words, upper-lane stores must be dropped
                for (i = 0; i < 10; i++) begin
                        a = (i < 8) ? 12'h820 + 12'(4 * i) : 12'h840 + 12'(4 * (i - 8));
                        do_store(a, $random(seed) | 32'h80, 4'b1111);
                        do_store(a, $random(seed), i[0] ? 4'b1100 : 4'b0010);
                        check_load(a, 4'b1111);
                        check_load(a, 4'b0001);
                        check_pins();
                end
                check_load(12'h848, 4'b1111);
                finish_test("hex and led registers");

                for (i = 0; i < 16; i++) begin
                        a = {3'd5 + 3'(i % 3), 9'($random(seed))};
                        do_store(a, $random(seed), 4'b1111);
                        check_load(a, 4'b1111);
                        check_load(a, 4'b0001 << (i % 4));
                end
                // Same low bits as the data words
                for (i = 0; i < 32; i++) begin
                        do_store(addr_list[i] | 12'hA00, 32'hFFFF_FFFF, 4'b1111);
                end
                for (i = 0; i < 32; i++) begin
                        check_load(addr_list[i], 4'b1111);
                end
                check_pins();
                finish_test("reserved region");

                $display("Tests passed %0d, failed %0d, checks %0d, errors %0d",
                         tests_passed, tests_failed, checks, errors);
                if (errors == 0 && tests_failed == 0) begin
                        $display("Simulation completed successfully");
                end else begin
                        $display("Simulation failed");
                end
                $finish;
        end

endmodule

`default_nettype wire
